/* compile.f */
rtl/csr_types_pkg.sv
rtl/csr_addr_pkg.sv
rtl/csr_write_decode.sv
rtl/privilege_ctrl.sv
rtl/csr_regs.sv
rtl/csr_read_mux.sv
rtl/csr_file.sv
dv/csr_file_assert.sv
dv/csr_file_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the CSR file testbench with Verilator, run it and scan the log.
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module csr_file_tb -o csr_file_sim
./obj_dir/csr_file_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"

/* dv/csr_file_tb.sv */
// Directed testbench for the CSR file. Covers reset state, register read-back,
// status views, machine and delegated traps with their returns, and the cycle counter.
// Top module is csr_file_tb; sources come from compile.f.
`timescale 1ns/1ps
`default_nettype none

module csr_file_tb;

    // The tests use about 150 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    // Status layout worked out by hand: bits 1,3,5,7,8,11,12 and 1,5,8
    localparam logic [31:0] MSTATUS_BITS = 32'h0000_19aa;
    localparam logic [31:0] SSTATUS_BITS = 32'h0000_0122;
    localparam logic [31:0] MISA_RV32I   = 32'h4000_0100;

    logic                    clk;
    logic                    rst;
    csr_addr_pkg::csr_addr_t read_addr;
    logic                    write_enable;
    csr_addr_pkg::csr_addr_t write_addr;
    csr_types_pkg::word_t    write_value;
    logic                    trap_valid;
    csr_types_pkg::cause_t   trap_cause;
    csr_types_pkg::word_t    trap_value;
    csr_types_pkg::word_t    trap_pc;
    logic                    trap_return;
    csr_types_pkg::priv_e    trap_return_priv;
    csr_types_pkg::word_t    read_value;
    csr_types_pkg::word_t    next_pc;
    csr_types_pkg::priv_e    privilege;
    csr_types_pkg::word_t    mstatus;

    int          errors;
    int          checks;
    int          cycle_count;
    logic [15:0] lfsr_state;

    csr_file dut0 (
        .clk              (clk),
        .rst              (rst),
        .read_addr        (read_addr),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .write_value      (write_value),
        .trap_valid       (trap_valid),
        .trap_cause       (trap_cause),
        .trap_value       (trap_value),
        .trap_pc          (trap_pc),
        .trap_return      (trap_return),
        .trap_return_priv (trap_return_priv),
        .read_value       (read_value),
        .next_pc          (next_pc),
        .privilege        (privilege),
        .mstatus          (mstatus)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus helpers

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    task automatic rand_bits(input int n, output csr_types_pkg::word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic to_drive_point();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input csr_types_pkg::word_t exp,
                              input csr_types_pkg::word_t act);
        checks = checks + 1;
        if (act !== exp) begin
            $display("ERROR %s: expected %h, got %h", name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic check_priv(input string name, input csr_types_pkg::priv_e exp,
                              input csr_types_pkg::priv_e act);
        checks = checks + 1;
        if (act !== exp) begin
            $display("ERROR %s: expected %h, got %h", name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic read_csr(input csr_addr_pkg::csr_addr_t addr,
                            input csr_types_pkg::word_t exp);
        read_addr = addr;
        #5;
        check_word($sformatf("read_value[%h]", addr), exp, read_value);
        to_drive_point();
    endtask

    task automatic write_csr(input csr_addr_pkg::csr_addr_t addr,
                             input csr_types_pkg::word_t value);
        write_enable = 1'b1;
        write_addr   = addr;
        write_value  = value;
        to_drive_point();
        write_enable = 1'b0;
    endtask

    task automatic take_trap(input csr_types_pkg::cause_t cause, input csr_types_pkg::word_t tval,
                             input csr_types_pkg::word_t pc, input csr_types_pkg::word_t exp_pc);
        trap_valid = 1'b1;
        trap_cause = cause;
        trap_value = tval;
        trap_pc    = pc;
        #5;
        check_word("next_pc", exp_pc, next_pc);
        to_drive_point();
        trap_valid = 1'b0;
    endtask

    task automatic take_return(input csr_types_pkg::priv_e from_priv,
                               input csr_types_pkg::word_t exp_pc);
        trap_return      = 1'b1;
        trap_return_priv = from_priv;
        #5;
        check_word("next_pc", exp_pc, next_pc);
        to_drive_point();
        trap_return = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // Tests

    task automatic test_reset();
        csr_addr_pkg::csr_addr_t zero_addrs [14];
        zero_addrs = '{csr_addr_pkg::ADDR_SSTATUS, csr_addr_pkg::ADDR_STVEC,
                       csr_addr_pkg::ADDR_SSCRATCH, csr_addr_pkg::ADDR_SEPC,
                       csr_addr_pkg::ADDR_SCAUSE, csr_addr_pkg::ADDR_STVAL,
                       csr_addr_pkg::ADDR_MSTATUS, csr_addr_pkg::ADDR_MEDELEG,
                       csr_addr_pkg::ADDR_MTVEC, csr_addr_pkg::ADDR_MSCRATCH,
                       csr_addr_pkg::ADDR_MEPC, csr_addr_pkg::ADDR_MCAUSE,
                       csr_addr_pkg::ADDR_MTVAL, csr_addr_pkg::ADDR_CYCLEH};
        check_priv("privilege", csr_types_pkg::PRIV_MACHINE, privilege);
        check_word("mstatus", '0, mstatus);
        check_word("next_pc", '0, next_pc);
        foreach (zero_addrs[i]) begin
            read_csr(zero_addrs[i], '0);
        end
        read_csr(csr_addr_pkg::ADDR_MISA, MISA_RV32I);
        read_csr(12'h7c0, '0);
    endtask

    task automatic test_readback();
        csr_addr_pkg::csr_addr_t word_addrs [9];
        csr_types_pkg::word_t    v;
        word_addrs = '{csr_addr_pkg::ADDR_MSCRATCH, csr_addr_pkg::ADDR_SSCRATCH,
                       csr_addr_pkg::ADDR_MEPC, csr_addr_pkg::ADDR_SEPC,
                       csr_addr_pkg::ADDR_MTVAL, csr_addr_pkg::ADDR_STVAL,
                       csr_addr_pkg::ADDR_MTVEC, csr_addr_pkg::ADDR_STVEC,
                       csr_addr_pkg::ADDR_MEDELEG};
        foreach (word_addrs[i]) begin
            rand_bits(32, v);
            write_csr(word_addrs[i], v);
            read_csr(word_addrs[i], v);
        end
        // Cause registers keep the exception code only
        rand_bits(32, v);
        write_csr(csr_addr_pkg::ADDR_MCAUSE, v);
        read_csr(csr_addr_pkg::ADDR_MCAUSE, v & 32'hf);
        rand_bits(32, v);
        write_csr(csr_addr_pkg::ADDR_SCAUSE, v);
        read_csr(csr_addr_pkg::ADDR_SCAUSE, v & 32'hf);
    endtask

    task automatic test_status();
        csr_types_pkg::word_t v;
        csr_types_pkg::word_t expected;
        rand_bits(32, v);
        expected = v & MSTATUS_BITS;
        if (expected[12:11] == 2'b10) begin
            expected[12:11] = 2'b00;
        end
        write_csr(csr_addr_pkg::ADDR_MSTATUS, v);
        read_csr(csr_addr_pkg::ADDR_MSTATUS, expected);
        // Reserved mpp encoding reads back as user
        rand_bits(32, v);
        v[12:11] = 2'b10;
        write_csr(csr_addr_pkg::ADDR_MSTATUS, v);
        expected = v & MSTATUS_BITS & ~32'h0000_1800;
        read_csr(csr_addr_pkg::ADDR_MSTATUS, expected);
        read_csr(csr_addr_pkg::ADDR_SSTATUS, expected & SSTATUS_BITS);
        rand_bits(32, v);
        write_csr(csr_addr_pkg::ADDR_SSTATUS, v);
        expected = (expected & ~SSTATUS_BITS) | (v & SSTATUS_BITS);
        read_csr(csr_addr_pkg::ADDR_MSTATUS, expected);
        check_word("mstatus", expected, mstatus);
    endtask

    task automatic test_machine_trap();
        csr_types_pkg::word_t vec;
        csr_types_pkg::word_t pc;
        csr_types_pkg::word_t tval;
        csr_types_pkg::word_t c;
        write_csr(csr_addr_pkg::ADDR_MEDELEG, '0);
        rand_bits(32, vec);
        write_csr(csr_addr_pkg::ADDR_MTVEC, vec);
        write_csr(csr_addr_pkg::ADDR_MSTATUS, 32'h0000_0080);
        rand_bits(32, pc);
        rand_bits(32, tval);
        rand_bits(4, c);
        // Status write alongside the trap, to be dropped
        write_enable = 1'b1;
        write_addr   = csr_addr_pkg::ADDR_MSTATUS;
        write_value  = 32'hffff_ffff;
        take_trap(c[3:0], tval, pc, {vec[31:2], 2'b00});
        write_enable = 1'b0;
        read_csr(csr_addr_pkg::ADDR_MEPC, pc);
        read_csr(csr_addr_pkg::ADDR_MCAUSE, c);
        read_csr(csr_addr_pkg::ADDR_MTVAL, tval);
        read_csr(csr_addr_pkg::ADDR_MSTATUS, 32'h0000_1880);
        check_priv("privilege", csr_types_pkg::PRIV_MACHINE, privilege);
        take_return(csr_types_pkg::PRIV_MACHINE, pc);
        check_priv("privilege", csr_types_pkg::PRIV_MACHINE, privilege);
        check_word("mstatus", 32'h0000_0088, mstatus);
    endtask

    task automatic test_delegated_trap();
        csr_types_pkg::word_t epc;
        csr_types_pkg::word_t vec;
        csr_types_pkg::word_t pc;
        csr_types_pkg::word_t tval;
        csr_types_pkg::word_t c;
        // mpp supervisor and spie set before dropping out of machine mode
        write_csr(csr_addr_pkg::ADDR_MSTATUS, 32'h0000_0820);
        rand_bits(32, epc);
        write_csr(csr_addr_pkg::ADDR_MEPC, epc);
        rand_bits(32, vec);
        write_csr(csr_addr_pkg::ADDR_STVEC, vec);
        rand_bits(4, c);
        write_csr(csr_addr_pkg::ADDR_MEDELEG, 32'h1 << c);
        take_return(csr_types_pkg::PRIV_MACHINE, epc);
        check_priv("privilege", csr_types_pkg::PRIV_SUPERVISOR, privilege);
        check_word("mstatus", 32'h0000_0020, mstatus);
        rand_bits(32, pc);
        rand_bits(32, tval);
        take_trap(c[3:0], tval, pc, {vec[31:2], 2'b00});
        read_csr(csr_addr_pkg::ADDR_SEPC, pc);
        read_csr(csr_addr_pkg::ADDR_SCAUSE, c);
        read_csr(csr_addr_pkg::ADDR_STVAL, tval);
        read_csr(csr_addr_pkg::ADDR_MSTATUS, 32'h0000_0120);
        check_priv("privilege", csr_types_pkg::PRIV_SUPERVISOR, privilege);
        take_return(csr_types_pkg::PRIV_SUPERVISOR, pc);
        check_priv("privilege", csr_types_pkg::PRIV_SUPERVISOR, privilege);
        check_word("mstatus", 32'h0000_0022, mstatus);
    endtask

    task automatic test_cycle();
        csr_types_pkg::word_t c0;
        csr_types_pkg::word_t n;
        rand_bits(3, n);
        n = n + 4;
        read_addr = csr_addr_pkg::ADDR_CYCLE;
        #4;
        c0 = read_value;
        read_addr = csr_addr_pkg::ADDR_TIME;
        #4;
        check_word("read_value[time]", c0, read_value);
        repeat (n) to_drive_point();
        read_csr(csr_addr_pkg::ADDR_CYCLE, c0 + n);
        read_csr(csr_addr_pkg::ADDR_CYCLEH, '0);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    initial begin
        clk              = 1'b0;
        rst              = 1'b1;
        read_addr        = '0;
        write_enable     = 1'b0;
        write_addr       = '0;
        write_value      = '0;
        trap_valid       = 1'b0;
        trap_cause       = '0;
        trap_value       = '0;
        trap_pc          = '0;
        trap_return      = 1'b0;
        trap_return_priv = csr_types_pkg::PRIV_USER;
        errors           = 0;
        checks           = 0;
        cycle_count      = 0;
        lfsr_state       = 16'd47;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_readback();
        test_status();
        test_machine_trap();
        test_delegated_trap();
        test_cycle();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/csr_file_assert.sv */
// Concurrent assertions on the privilege/trap controller.
// Attached to every privilege_ctrl instance by the bind at the end of this file.
`timescale 1ns/1ps
`default_nettype none

module csr_file_assert (
    input logic        clk,
    input logic        rst,
    input logic [1:0]  privilege,
    input logic        trap_valid,
    input logic        trap_to_m,
    input logic        trap_to_s,
    input logic [31:0] next_pc
);

    // Encoding 2 is reserved
    a_priv_legal: assert property (@(posedge clk) disable iff (rst) privilege != 2'd2)
        else $error("privilege holds the reserved value 2");

    a_one_target: assert property (@(posedge clk) disable iff (rst) !(trap_to_m && trap_to_s))
        else $error("trap routed to machine and supervisor at once");

    // Trap targets come from an aligned vector
    a_trap_aligned: assert property (@(posedge clk) disable iff (rst)
        trap_valid |-> next_pc[1:0] == 2'b00)
        else $error("trap target has low bits set");

endmodule

bind privilege_ctrl csr_file_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .privilege  (privilege),
    .trap_valid (trap_valid),
    .trap_to_m  (trap_to_m),
    .trap_to_s  (trap_to_s),
    .next_pc    (next_pc)
);

`default_nettype wire

/* rtl/csr_file.sv */
// Top level of the CSR file: write decoder, privilege/trap controller,
// register storage and read multiplexer, connected by loose wires.
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  logic                    clk,
    input  logic                    rst,
    input  csr_addr_pkg::csr_addr_t read_addr,
    input  logic                    write_enable,
    input  csr_addr_pkg::csr_addr_t write_addr,
    input  csr_types_pkg::word_t    write_value,
    input  logic                    trap_valid,
    input  csr_types_pkg::cause_t   trap_cause,
    input  csr_types_pkg::word_t    trap_value,
    input  csr_types_pkg::word_t    trap_pc,
    input  logic                    trap_return,
    input  csr_types_pkg::priv_e    trap_return_priv,
    output csr_types_pkg::word_t    read_value,
    output csr_types_pkg::word_t    next_pc,
    output csr_types_pkg::priv_e    privilege,
    output csr_types_pkg::word_t    mstatus
);

    // Write strobes
    logic wr_mstatus, wr_sstatus, wr_medeleg, wr_mtvec, wr_mscratch;
    logic wr_mepc, wr_mcause, wr_mtval;
    logic wr_stvec, wr_sscratch, wr_sepc, wr_scause, wr_stval;

    logic trap_to_m;
    logic trap_to_s;

    csr_types_pkg::word_t  medeleg, mtvec, mscratch, mepc, mtval;
    csr_types_pkg::word_t  stvec, sscratch, sepc, stval;
    csr_types_pkg::cause_t mcause, scause;
    csr_types_pkg::cycle_t cycle;

    csr_write_decode u_decode (
        .write_enable, .write_addr,
        .wr_mstatus, .wr_sstatus, .wr_medeleg, .wr_mtvec, .wr_mscratch,
        .wr_mepc, .wr_mcause, .wr_mtval,
        .wr_stvec, .wr_sscratch, .wr_sepc, .wr_scause, .wr_stval
    );

    privilege_ctrl u_priv (
        .clk, .rst,
        .trap_valid, .trap_cause, .trap_return, .trap_return_priv,
        .wr_mstatus, .wr_sstatus, .write_value,
        .medeleg, .mtvec, .stvec, .mepc, .sepc,
        .trap_to_m, .trap_to_s,
        .next_pc, .privilege, .mstatus
    );

    csr_regs u_regs (
        .clk, .rst, .write_value,
        .trap_value, .trap_pc, .trap_cause, .trap_to_m, .trap_to_s,
        .wr_medeleg, .wr_mtvec, .wr_mscratch, .wr_mepc, .wr_mcause, .wr_mtval,
        .wr_stvec, .wr_sscratch, .wr_sepc, .wr_scause, .wr_stval,
        .medeleg, .mtvec, .mscratch, .mepc, .mtval,
        .stvec, .sscratch, .sepc, .stval,
        .mcause, .scause, .cycle
    );

    csr_read_mux u_read (
        .read_addr, .mstatus,
        .medeleg, .mtvec, .mscratch, .mepc, .mtval,
        .stvec, .sscratch, .sepc, .stval,
        .mcause, .scause, .cycle,
        .read_value
    );

endmodule

`default_nettype wire

/* rtl/csr_read_mux.sv */
// Combinational CSR read port. Selects the stored value by read address,
// including the sstatus view and the counter halves; unknown addresses read 0.
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux (
    input  csr_addr_pkg::csr_addr_t read_addr,
    input  csr_types_pkg::word_t    mstatus,
    input  csr_types_pkg::word_t    medeleg,
    input  csr_types_pkg::word_t    mtvec,
    input  csr_types_pkg::word_t    mscratch,
    input  csr_types_pkg::word_t    mepc,
    input  csr_types_pkg::word_t    mtval,
    input  csr_types_pkg::word_t    stvec,
    input  csr_types_pkg::word_t    sscratch,
    input  csr_types_pkg::word_t    sepc,
    input  csr_types_pkg::word_t    stval,
    input  csr_types_pkg::cause_t   mcause,
    input  csr_types_pkg::cause_t   scause,
    input  csr_types_pkg::cycle_t   cycle,
    output csr_types_pkg::word_t    read_value
);

    localparam int PAD_W = csr_types_pkg::WORD_W - csr_types_pkg::CAUSE_W;

    always_comb begin
        case (read_addr)
            csr_addr_pkg::ADDR_SSTATUS:  read_value = mstatus & csr_types_pkg::SSTATUS_MASK;
            csr_addr_pkg::ADDR_STVEC:    read_value = stvec;
            csr_addr_pkg::ADDR_SSCRATCH: read_value = sscratch;
            csr_addr_pkg::ADDR_SEPC:     read_value = sepc;
            csr_addr_pkg::ADDR_SCAUSE:   read_value = {{PAD_W{1'b0}}, scause};
            csr_addr_pkg::ADDR_STVAL:    read_value = stval;
            csr_addr_pkg::ADDR_MSTATUS:  read_value = mstatus;
            csr_addr_pkg::ADDR_MISA:     read_value = csr_types_pkg::MISA_VALUE;
            csr_addr_pkg::ADDR_MEDELEG:  read_value = medeleg;
            csr_addr_pkg::ADDR_MTVEC:    read_value = mtvec;
            csr_addr_pkg::ADDR_MSCRATCH: read_value = mscratch;
            csr_addr_pkg::ADDR_MEPC:     read_value = mepc;
            csr_addr_pkg::ADDR_MCAUSE:   read_value = {{PAD_W{1'b0}}, mcause};
            csr_addr_pkg::ADDR_MTVAL:    read_value = mtval;
            // time is an alias of cycle
            csr_addr_pkg::ADDR_CYCLE,
            csr_addr_pkg::ADDR_TIME:     read_value = cycle[31:0];
            csr_addr_pkg::ADDR_CYCLEH,
            csr_addr_pkg::ADDR_TIMEH:    read_value = cycle[63:32];
            default:                     read_value = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/csr_regs.sv */
// Storage for the trap-handling, vector, scratch and delegation CSRs and
// the free-running cycle counter. Trap loads take priority over writes.
`timescale 1ns/1ps
`default_nettype none

module csr_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  csr_types_pkg::word_t   write_value,
    input  csr_types_pkg::word_t   trap_value,
    input  csr_types_pkg::word_t   trap_pc,
    input  csr_types_pkg::cause_t  trap_cause,
    input  logic                   trap_to_m,
    input  logic                   trap_to_s,
    input  logic                   wr_medeleg,
    input  logic                   wr_mtvec,
    input  logic                   wr_mscratch,
    input  logic                   wr_mepc,
    input  logic                   wr_mcause,
    input  logic                   wr_mtval,
    input  logic                   wr_stvec,
    input  logic                   wr_sscratch,
    input  logic                   wr_sepc,
    input  logic                   wr_scause,
    input  logic                   wr_stval,
    output csr_types_pkg::word_t   medeleg,
    output csr_types_pkg::word_t   mtvec,
    output csr_types_pkg::word_t   mscratch,
    output csr_types_pkg::word_t   mepc,
    output csr_types_pkg::word_t   mtval,
    output csr_types_pkg::word_t   stvec,
    output csr_types_pkg::word_t   sscratch,
    output csr_types_pkg::word_t   sepc,
    output csr_types_pkg::word_t   stval,
    output csr_types_pkg::cause_t  mcause,
    output csr_types_pkg::cause_t  scause,
    output csr_types_pkg::cycle_t  cycle
);

    csr_types_pkg::cause_t write_cause;

    // Cause writes keep only the exception code
    assign write_cause = write_value[csr_types_pkg::CAUSE_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            medeleg  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            stvec    <= '0;
            sscratch <= '0;
            sepc     <= '0;
            scause   <= '0;
            stval    <= '0;
            cycle    <= '0;
        end else begin
            cycle <= cycle + csr_types_pkg::cycle_t'(1);

            // Written only by instructions
            if (wr_medeleg)  medeleg  <= write_value;
            if (wr_mtvec)    mtvec    <= write_value;
            if (wr_mscratch) mscratch <= write_value;
            if (wr_stvec)    stvec    <= write_value;
            if (wr_sscratch) sscratch <= write_value;

            // ------------------------------------------------------------------
            // Trap state of each mode
            if (trap_to_m) begin
                mepc   <= trap_pc;
                mcause <= trap_cause;
                mtval  <= trap_value;
            end else begin
                if (wr_mepc)   mepc   <= write_value;
                if (wr_mcause) mcause <= write_cause;
                if (wr_mtval)  mtval  <= write_value;
            end

            if (trap_to_s) begin
                sepc   <= trap_pc;
                scause <= trap_cause;
                stval  <= trap_value;
            end else begin
                if (wr_sepc)   sepc   <= write_value;
                if (wr_scause) scause <= write_cause;
                if (wr_stval)  stval  <= write_value;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/privilege_ctrl.sv */
// Privilege and trap controller. Holds the current privilege and mstatus,
// routes traps by medeleg, applies mret/sret and status writes, and forms
// the next PC of a trap or a return in the same cycle.
`timescale 1ns/1ps
`default_nettype none

module privilege_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 trap_valid,
    input  csr_types_pkg::cause_t trap_cause,
    input  logic                 trap_return,
    input  csr_types_pkg::priv_e trap_return_priv,
    input  logic                 wr_mstatus,
    input  logic                 wr_sstatus,
    input  csr_types_pkg::word_t write_value,
    input  csr_types_pkg::word_t medeleg,
    input  csr_types_pkg::word_t mtvec,
    input  csr_types_pkg::word_t stvec,
    input  csr_types_pkg::word_t mepc,
    input  csr_types_pkg::word_t sepc,
    output logic                 trap_to_m,
    output logic                 trap_to_s,
    output csr_types_pkg::word_t next_pc,
    output csr_types_pkg::priv_e privilege,
    output csr_types_pkg::word_t mstatus
);

    localparam int MPP_LO = csr_types_pkg::STATUS_MPP_LO;
    localparam int MPP_HI = csr_types_pkg::STATUS_MPP_HI;

    logic                 do_mret;
    logic                 do_sret;
    csr_types_pkg::priv_e priv_next;
    csr_types_pkg::word_t status_next;
    csr_types_pkg::word_t status_wr;

    // ----------------------------------------------------------------------
    // Trap routing and return decode
    assign trap_to_s = trap_valid && medeleg[trap_cause];
    assign trap_to_m = trap_valid && !medeleg[trap_cause];

    // A trap in the same cycle wins over a return
    assign do_mret = trap_return && !trap_valid &&
                     (trap_return_priv == csr_types_pkg::PRIV_MACHINE);
    assign do_sret = trap_return && !trap_valid &&
                     (trap_return_priv == csr_types_pkg::PRIV_SUPERVISOR);

    always_comb begin
        if (trap_to_m) begin
            next_pc = mtvec & csr_types_pkg::TVEC_ALIGN_MASK;
        end else if (trap_to_s) begin
            next_pc = stvec & csr_types_pkg::TVEC_ALIGN_MASK;
        end else if (do_mret) begin
            next_pc = mepc;
        end else if (do_sret) begin
            next_pc = sepc;
        end else begin
            next_pc = '0;
        end
    end

    // ----------------------------------------------------------------------
    // Next privilege and status
    always_comb begin
        // Full mstatus write, reserved mpp value 2 folds to user
        status_wr = write_value & csr_types_pkg::MSTATUS_MASK;
        if (status_wr[MPP_HI:MPP_LO] == 2'b10) begin
            status_wr[MPP_HI:MPP_LO] = 2'b00;
        end

        priv_next   = privilege;
        status_next = mstatus;
        if (trap_to_m) begin
            priv_next = csr_types_pkg::PRIV_MACHINE;
            status_next[MPP_HI:MPP_LO] = privilege;
        end else if (trap_to_s) begin
            priv_next = csr_types_pkg::PRIV_SUPERVISOR;
            status_next[csr_types_pkg::STATUS_SPP] = privilege[0];
        end else if (do_mret) begin
            priv_next = csr_types_pkg::priv_e'(mstatus[MPP_HI:MPP_LO]);
            status_next[csr_types_pkg::STATUS_MIE] = mstatus[csr_types_pkg::STATUS_MPIE];
            status_next[MPP_HI:MPP_LO] = csr_types_pkg::PRIV_USER;
        end else if (do_sret) begin
            priv_next = csr_types_pkg::priv_e'({1'b0, mstatus[csr_types_pkg::STATUS_SPP]});
            status_next[csr_types_pkg::STATUS_SIE] = mstatus[csr_types_pkg::STATUS_SPIE];
            status_next[csr_types_pkg::STATUS_SPP] = 1'b0;
        end else if (wr_mstatus) begin
            status_next = status_wr;
        end else if (wr_sstatus) begin
            status_next = (mstatus & ~csr_types_pkg::SSTATUS_MASK) |
                          (write_value & csr_types_pkg::SSTATUS_MASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            privilege <= csr_types_pkg::PRIV_MACHINE;
            mstatus   <= '0;
        end else begin
            privilege <= priv_next;
            mstatus   <= status_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/csr_write_decode.sv */
// Write address decoder of the CSR file. It turns one CSR write into a
// strobe for the addressed register; read-only and unknown addresses raise none.
`timescale 1ns/1ps
`default_nettype none

module csr_write_decode (
    input  logic                   write_enable,
    input  csr_addr_pkg::csr_addr_t write_addr,
    output logic                   wr_mstatus,
    output logic                   wr_sstatus,
    output logic                   wr_medeleg,
    output logic                   wr_mtvec,
    output logic                   wr_mscratch,
    output logic                   wr_mepc,
    output logic                   wr_mcause,
    output logic                   wr_mtval,
    output logic                   wr_stvec,
    output logic                   wr_sscratch,
    output logic                   wr_sepc,
    output logic                   wr_scause,
    output logic                   wr_stval
);

    // Machine registers
    assign wr_mstatus  = write_enable && (write_addr == csr_addr_pkg::ADDR_MSTATUS);
    assign wr_medeleg  = write_enable && (write_addr == csr_addr_pkg::ADDR_MEDELEG);
    assign wr_mtvec    = write_enable && (write_addr == csr_addr_pkg::ADDR_MTVEC);
    assign wr_mscratch = write_enable && (write_addr == csr_addr_pkg::ADDR_MSCRATCH);
    assign wr_mepc     = write_enable && (write_addr == csr_addr_pkg::ADDR_MEPC);
    assign wr_mcause   = write_enable && (write_addr == csr_addr_pkg::ADDR_MCAUSE);
    assign wr_mtval    = write_enable && (write_addr == csr_addr_pkg::ADDR_MTVAL);

    // Supervisor registers
    assign wr_sstatus  = write_enable && (write_addr == csr_addr_pkg::ADDR_SSTATUS);
    assign wr_stvec    = write_enable && (write_addr == csr_addr_pkg::ADDR_STVEC);
    assign wr_sscratch = write_enable && (write_addr == csr_addr_pkg::ADDR_SSCRATCH);
    assign wr_sepc     = write_enable && (write_addr == csr_addr_pkg::ADDR_SEPC);
    assign wr_scause   = write_enable && (write_addr == csr_addr_pkg::ADDR_SCAUSE);
    assign wr_stval    = write_enable && (write_addr == csr_addr_pkg::ADDR_STVAL);

endmodule

`default_nettype wire

/* rtl/csr_addr_pkg.sv */
// Address map of the CSR file, limited to the registers it implements.
// Shared by the write decoder, the read multiplexer and the testbench.
`default_nettype none

package csr_addr_pkg;

    typedef logic [11:0] csr_addr_t;

    // Supervisor trap setup and handling
    localparam csr_addr_t ADDR_SSTATUS  = 12'h100;
    localparam csr_addr_t ADDR_STVEC    = 12'h105;
    localparam csr_addr_t ADDR_SSCRATCH = 12'h140;
    localparam csr_addr_t ADDR_SEPC     = 12'h141;
    localparam csr_addr_t ADDR_SCAUSE   = 12'h142;
    localparam csr_addr_t ADDR_STVAL    = 12'h143;

    // Machine trap setup and handling
    localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t ADDR_MISA     = 12'h301;
    localparam csr_addr_t ADDR_MEDELEG  = 12'h302;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MTVAL    = 12'h343;

    // Counters, read only
    localparam csr_addr_t ADDR_CYCLE    = 12'hc00;
    localparam csr_addr_t ADDR_TIME     = 12'hc01;
    localparam csr_addr_t ADDR_CYCLEH   = 12'hc80;
    localparam csr_addr_t ADDR_TIMEH    = 12'hc81;

endpackage

`default_nettype wire

/* rtl/csr_types_pkg.sv */
// Data, cause and privilege types shared by the CSR file modules, along with
// the mstatus field layout and the constant CSR values.
// Modules refer to these items by scoped name.
`default_nettype none

package csr_types_pkg;

    localparam int WORD_W  = 32;
    localparam int CAUSE_W = 4;
    localparam int CYCLE_W = 64;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [CAUSE_W-1:0] cause_t;
    typedef logic [CYCLE_W-1:0] cycle_t;

    // Value 2 is reserved and never held
    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } priv_e;

    // ----------------------------------------------------------------------
    // mstatus field positions
    localparam int STATUS_SIE    = 1;
    localparam int STATUS_MIE    = 3;
    localparam int STATUS_SPIE   = 5;
    localparam int STATUS_MPIE   = 7;
    localparam int STATUS_SPP    = 8;
    localparam int STATUS_MPP_LO = 11;
    localparam int STATUS_MPP_HI = 12;

    // ----------------------------------------------------------------------
    // Masks and constants
    localparam word_t SSTATUS_MASK = (word_t'(1) << STATUS_SIE) |
                                     (word_t'(1) << STATUS_SPIE) |
                                     (word_t'(1) << STATUS_SPP);

    localparam word_t MSTATUS_MASK = SSTATUS_MASK |
                                     (word_t'(1) << STATUS_MIE) |
                                     (word_t'(1) << STATUS_MPIE) |
                                     (word_t'(3) << STATUS_MPP_LO);

    localparam word_t TVEC_ALIGN_MASK = ~word_t'(3);

    // RV32I base, no extensions
    localparam word_t MISA_VALUE = 32'h4000_0100;

endpackage

`default_nettype wire
